// File: design/cache_pkg.sv
package cache_pkg;

   // address and data widths
   localparam int addr_w         = 32;
   localparam int data_w         = 32;

   // byte address = {tag, index, word offset, byte offset}
   localparam int byte_off_w     = 2;
   localparam int word_off_w     = 2;
   localparam int index_w        = 4;   // 16 lines
   localparam int tag_w          = addr_w - index_w - word_off_w - byte_off_w;
   localparam int words_per_line = 1 << word_off_w;

   // one line = one incrementing burst of 32-bit beats
   localparam logic [7:0] burst_len  = 8'(words_per_line - 1);
   localparam logic [2:0] burst_size = 3'(byte_off_w);   // 4 bytes per beat
   localparam logic [1:0] burst_incr = 2'b01;
   localparam logic [1:0] resp_okay  = 2'b00;

   // wishbone classic front port
   typedef struct packed {
      logic [addr_w-1:0] adr;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      logic [data_w-1:0] dat;
      logic              ack;
   } wb_rsp_t;

   // axi read address payload, valid/ready travel beside it
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [7:0]        len;
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_ar_t;

   // axi read data payload
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

   // tag store entry
   typedef struct packed {
      logic             valid;
      logic [tag_w-1:0] tag;
   } tag_entry_t;

   // data store entry, one word
   typedef logic [data_w-1:0] line_word_t;

endpackage

// File: design/line_store.sv
`timescale 1ns/1ps

module line_store #(
   parameter type entry_t = logic [31:0],
   parameter int  depth   = 16
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     we,
   input  logic [$clog2(depth)-1:0] waddr,
   input  logic [$clog2(depth)-1:0] raddr,
   input  entry_t                   wdata,
   output entry_t                   rdata
);

   entry_t mem [depth];

   // cleared on reset so tag entries start invalid
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < depth; i++)
            mem[i] <= '0;
      end
      else if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   assign rdata = mem[raddr];   // combinational read

endmodule

// File: design/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup (
   input  logic                                  clk,
   input  logic                                  reset,
   input  cache_pkg::wb_req_t                    wb_req,
   output cache_pkg::wb_rsp_t                    wb_rsp,
   input  cache_pkg::tag_entry_t                 tag_rd,
   input  cache_pkg::line_word_t                 data_rd,
   output logic [cache_pkg::index_w-1:0]         rd_index,
   output logic [cache_pkg::word_off_w-1:0]      rd_word,
   output logic                                  miss_valid,
   output logic [cache_pkg::tag_w+cache_pkg::index_w-1:0] miss_line,
   input  logic                                  refill_busy
);

   typedef enum logic [1:0] {
      st_idle,
      st_wait,   // miss issued, refill running
      st_gap     // ack cycle, strobe still high
   } state_t;

   state_t                     state;
   logic [cache_pkg::tag_w-1:0] req_tag;
   logic                       req_on;
   logic                       hit;
   logic                       lookup_en;
   logic                       ack_q;
   cache_pkg::line_word_t      dat_q;

   // address split
   assign req_tag  = wb_req.adr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
   assign rd_index = wb_req.adr[cache_pkg::byte_off_w+cache_pkg::word_off_w +: cache_pkg::index_w];
   assign rd_word  = wb_req.adr[cache_pkg::byte_off_w +: cache_pkg::word_off_w];

   assign req_on = wb_req.cyc & wb_req.stb;
   assign hit    = tag_rd.valid && (tag_rd.tag == req_tag);

   // compare only when the stores are not being refilled
   assign lookup_en = (state == st_idle || state == st_wait) && req_on && !refill_busy;

   assign miss_valid = lookup_en && !hit;   // one cycle, refill leaves idle next edge
   assign miss_line  = {req_tag, rd_index};

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= st_idle;
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= lookup_en && hit;
         case (state)
            st_idle:
            begin
               if (lookup_en)
                  state <= hit ? st_gap : st_wait;
            end
            st_wait:
            begin
               // retry once the refill has let go of the stores
               if (!refill_busy)
               begin
                  if (!req_on)
                     state <= st_idle;   // request withdrawn
                  else if (hit)
                     state <= st_gap;
               end
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // read word captured on the hit
   always_ff @(posedge clk)
   begin
      if (lookup_en && hit)
         dat_q <= data_rd;
   end

   assign wb_rsp.dat = dat_q;
   assign wb_rsp.ack = ack_q;

endmodule

// File: design/line_refill_axi.sv
`timescale 1ns/1ps

module line_refill_axi (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  miss_valid,
   input  logic [cache_pkg::tag_w+cache_pkg::index_w-1:0] miss_line,
   output logic                                  refill_busy,
   output logic                                  arvalid,
   output cache_pkg::axi_ar_t                    ar,
   input  logic                                  arready,
   input  logic                                  rvalid,
   input  cache_pkg::axi_r_t                     r,
   output logic                                  rready,
   output logic                                  data_we,
   output logic [cache_pkg::index_w+cache_pkg::word_off_w-1:0] data_waddr,
   output cache_pkg::line_word_t                 data_wdata,
   output logic                                  tag_we,
   output logic [cache_pkg::index_w-1:0]         tag_waddr,
   output cache_pkg::tag_entry_t                 tag_wdata
);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,   // arvalid high
      st_load,   // receiving beats
      st_end     // tag write or retry
   } state_t;

   state_t                                          state;
   logic [cache_pkg::tag_w+cache_pkg::index_w-1:0]  line_q;
   logic [cache_pkg::word_off_w-1:0]                beat_q;
   logic                                            err_q;
   logic                                            beat;

   assign beat = rvalid && rready;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state  <= st_idle;
         beat_q <= '0;
         err_q  <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (miss_valid)
                  state <= st_addr;
            end
            st_addr:
            begin
               beat_q <= '0;
               if (arready)
                  state <= st_load;
            end
            st_load:
            begin
               if (beat)
               begin
                  beat_q <= beat_q + 1'b1;
                  // burst cannot be cut short, so keep the error until the end
                  if (r.resp != cache_pkg::resp_okay)
                     err_q <= 1'b1;
                  if (r.last)
                     state <= st_end;
               end
            end
            default:
            begin
               err_q <= 1'b0;
               state <= err_q ? st_addr : st_idle;   // whole burst again on error
            end
         endcase
      end
   end

   // line address held for the whole refill, including retries
   always_ff @(posedge clk)
   begin
      if (state == st_idle && miss_valid)
         line_q <= miss_line;
   end

   assign refill_busy = (state != st_idle);

   assign arvalid  = (state == st_addr);
   assign ar.addr  = {line_q, {(cache_pkg::word_off_w+cache_pkg::byte_off_w){1'b0}}};
   assign ar.len   = cache_pkg::burst_len;
   assign ar.size  = cache_pkg::burst_size;
   assign ar.burst = cache_pkg::burst_incr;

   assign rready = (state == st_load);

   // each accepted beat goes straight into the data store
   assign data_we    = beat;
   assign data_waddr = {line_q[cache_pkg::index_w-1:0], beat_q};
   assign data_wdata = r.data;

   assign tag_we          = (state == st_end) && !err_q;
   assign tag_waddr       = line_q[cache_pkg::index_w-1:0];
   assign tag_wdata.valid = 1'b1;
   assign tag_wdata.tag   = line_q[cache_pkg::tag_w+cache_pkg::index_w-1 -: cache_pkg::tag_w];

endmodule

// File: design/read_cache_top.sv
`timescale 1ns/1ps

module read_cache_top (
   input  logic                  clk,
   input  logic                  reset,
   input  cache_pkg::wb_req_t    wb_req,
   output cache_pkg::wb_rsp_t    wb_rsp,
   output logic                  arvalid,
   output cache_pkg::axi_ar_t    ar,
   input  logic                  arready,
   input  logic                  rvalid,
   input  cache_pkg::axi_r_t     r,
   output logic                  rready
);

   cache_pkg::tag_entry_t                                  tag_rd;
   cache_pkg::line_word_t                                  data_rd;
   logic [cache_pkg::index_w-1:0]                          rd_index;
   logic [cache_pkg::word_off_w-1:0]                       rd_word;
   logic                                                   miss_valid;
   logic [cache_pkg::tag_w+cache_pkg::index_w-1:0]         miss_line;
   logic                                                   refill_busy;
   logic                                                   data_we;
   logic [cache_pkg::index_w+cache_pkg::word_off_w-1:0]    data_waddr;
   cache_pkg::line_word_t                                  data_wdata;
   logic                                                   tag_we;
   logic [cache_pkg::index_w-1:0]                          tag_waddr;
   cache_pkg::tag_entry_t                                  tag_wdata;

   cache_lookup lookup (
      .clk         (clk),
      .reset       (reset),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp),
      .tag_rd      (tag_rd),
      .data_rd     (data_rd),
      .rd_index    (rd_index),
      .rd_word     (rd_word),
      .miss_valid  (miss_valid),
      .miss_line   (miss_line),
      .refill_busy (refill_busy)
   );

   line_refill_axi refill (
      .clk         (clk),
      .reset       (reset),
      .miss_valid  (miss_valid),
      .miss_line   (miss_line),
      .refill_busy (refill_busy),
      .arvalid     (arvalid),
      .ar          (ar),
      .arready     (arready),
      .rvalid      (rvalid),
      .r           (r),
      .rready      (rready),
      .data_we     (data_we),
      .data_waddr  (data_waddr),
      .data_wdata  (data_wdata),
      .tag_we      (tag_we),
      .tag_waddr   (tag_waddr),
      .tag_wdata   (tag_wdata)
   );

   // one entry per line
   line_store #(
      .entry_t (cache_pkg::tag_entry_t),
      .depth   (1 << cache_pkg::index_w)
   ) tag_store (
      .clk   (clk),
      .reset (reset),
      .we    (tag_we),
      .waddr (tag_waddr),
      .raddr (rd_index),
      .wdata (tag_wdata),
      .rdata (tag_rd)
   );

   // one entry per word, addressed by {index, word}
   line_store #(
      .entry_t (cache_pkg::line_word_t),
      .depth   ((1 << cache_pkg::index_w) * cache_pkg::words_per_line)
   ) data_store (
      .clk   (clk),
      .reset (reset),
      .we    (data_we),
      .waddr (data_waddr),
      .raddr ({rd_index, rd_word}),
      .wdata (data_wdata),
      .rdata (data_rd)
   );

endmodule

// File: verification/read_cache_chk.sv
`timescale 1ns/1ps

module read_cache_chk (
   input logic               clk,
   input logic               reset,
   input cache_pkg::wb_req_t wb_req,
   input cache_pkg::wb_rsp_t wb_rsp,
   input logic               arvalid,
   input cache_pkg::axi_ar_t ar,
   input logic               arready,
   input logic               rready
);

   logic ack_bad   = 1'b0;
   logic hold_bad  = 1'b0;
   logic ready_bad = 1'b0;
   logic shape_bad = 1'b0;
   logic failed;

   assign failed = ack_bad | hold_bad | ready_bad | shape_bad;

   // ack only answers a live request
   ack_with_req: assert property (@(posedge clk) disable iff (reset)
      wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
      else
      begin
         ack_bad = 1'b1;
         $error("ack while cyc or stb low");
      end

   ar_hold: assert property (@(posedge clk) disable iff (reset)
      arvalid && !arready |=> arvalid && $stable(ar))
      else
      begin
         hold_bad = 1'b1;
         $error("arvalid or ar changed before arready");
      end

   // address and data phases never overlap
   ready_excl: assert property (@(posedge clk) disable iff (reset) !(rready && arvalid))
      else
      begin
         ready_bad = 1'b1;
         $error("rready high while arvalid high");
      end

   ar_shape: assert property (@(posedge clk) disable iff (reset)
      ar.len == cache_pkg::burst_len && ar.size == cache_pkg::burst_size
         && ar.burst == cache_pkg::burst_incr && (!arvalid || ar.addr[3:0] == 4'd0))
      else
      begin
         shape_bad = 1'b1;
         $error("ar burst shape wrong or address not line aligned");
      end

endmodule

bind read_cache_top read_cache_chk chk (.*);

// File: verification/read_cache_tb.sv
`timescale 1ns/1ps

module read_cache_tb;

   localparam logic [31:0] pattern   = 32'h5a3c_96e1;
   localparam logic [31:0] line_a    = 32'h0000_1040;
   localparam logic [31:0] line_b    = 32'h0002_3040;   // same index as line_a
   localparam logic [31:0] err_line  = 32'h0000_5080;
   localparam int          ack_limit = 200;

   typedef enum logic [1:0] {m_idle, m_ar, m_data} mem_state_t;

   logic               clk;
   logic               reset;
   cache_pkg::wb_req_t wb_req;
   cache_pkg::wb_rsp_t wb_rsp;
   logic               arvalid;
   cache_pkg::axi_ar_t ar;
   logic               arready = 1'b0;
   logic               rvalid  = 1'b0;
   cache_pkg::axi_r_t  r       = '0;
   logic               rready;

   mem_state_t         m_state;
   logic [31:0]        burst_addr;
   logic [1:0]         beat_cnt;
   logic [1:0]         gap;
   logic [1:0]         draw;
   logic               inject;
   logic               err_done;
   logic [31:0]        lfsr = 32'd67125;
   int                 ar_count = 0;
   logic [31:0]        ar_log [$];

   read_cache_top uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // memory content rule
   function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
      return (byte_addr >> 2) ^ pattern;
   endfunction

   // fibonacci lfsr x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      return lfsr[0];
   endfunction

   function automatic logic [1:0] rand_gap();
      logic [1:0] g;
      g[1] = lfsr_bit();
      g[0] = lfsr_bit();
      return g;
   endfunction

   // read beat of the current burst
   function automatic cache_pkg::axi_r_t beat_word(input logic [1:0] idx);
      cache_pkg::axi_r_t b;
      b.data = mem_word(burst_addr + {idx, 2'b00});
      b.resp = (inject && idx == 2'd2) ? 2'b10 : cache_pkg::resp_okay;
      b.last = (idx == 2'd3);
      return b;
   endfunction

   // axi read slave with random arready delay and rvalid gaps
   always @(posedge clk)
   begin
      if (reset)
      begin
         m_state  <= m_idle;
         arready  <= 1'b0;
         rvalid   <= 1'b0;
         err_done <= 1'b0;
      end
      else
      begin
         case (m_state)
            m_idle:
            begin
               if (arvalid)
               begin
                  gap     <= rand_gap();
                  m_state <= m_ar;
               end
            end
            m_ar:
            begin
               if (arready)   // handshake on this edge
               begin
                  arready    <= 1'b0;
                  burst_addr <= ar.addr;
                  ar_count   <= ar_count + 1;
                  ar_log.push_back(ar.addr);
                  inject     <= (ar.addr == err_line) && !err_done;   // first burst only
                  err_done   <= err_done || (ar.addr == err_line);
                  beat_cnt   <= '0;
                  gap        <= rand_gap();
                  m_state    <= m_data;
               end
               else if (gap == 2'd0)
                  arready <= 1'b1;
               else
                  gap <= gap - 1'b1;
            end
            default:
            begin
               if (rvalid && rready)
               begin
                  draw = rand_gap();
                  beat_cnt <= beat_cnt + 1'b1;
                  if (r.last)
                  begin
                     rvalid  <= 1'b0;
                     m_state <= m_idle;
                  end
                  else if (draw == 2'd0)
                     r <= beat_word(beat_cnt + 1'b1);   // next beat back to back
                  else
                  begin
                     rvalid <= 1'b0;
                     gap    <= draw - 1'b1;
                  end
               end
               else if (!rvalid)
               begin
                  if (gap == 2'd0)
                  begin
                     rvalid <= 1'b1;
                     r      <= beat_word(beat_cnt);
                  end
                  else
                     gap <= gap - 1'b1;
               end
            end
         endcase
      end
   end

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // exp_ars and exp_lat below zero are not checked
   task automatic wb_read(input string name, input logic [31:0] adr, input int exp_ars,
                          input int exp_lat);
      int start_ars;
      int cycles;
      start_ars = ar_count;
      @(posedge clk);
      wb_req <= '{adr: adr, cyc: 1'b1, stb: 1'b1};
      cycles = 0;
      @(negedge clk);
      while (!wb_rsp.ack && cycles <= ack_limit)
      begin
         cycles++;
         @(negedge clk);
      end
      if (!wb_rsp.ack)
      begin
         $display("no ack within %0d cycles for read %s", ack_limit, name);
         $display("Test FAILED");
         $fatal(1, "ack timeout");
      end
      check_eq(name, mem_word(adr), wb_rsp.dat);
      if (exp_ars >= 0)
         check_eq({name, " ar count"}, exp_ars, ar_count - start_ars);
      if (exp_lat >= 0)
         check_eq({name, " latency"}, exp_lat, cycles);
      @(posedge clk);
      wb_req <= '{adr: adr, cyc: 1'b0, stb: 1'b0};
   endtask

   // protocol checker flags, stop at the first one
   always @(negedge clk)
   begin
      if (uut.chk.failed)
      begin
         $display("protocol assertion failed in read_cache_chk");
         $display("Test FAILED");
         $fatal(1, "protocol check");
      end
   end

   initial
   begin
      wb_req = '0;
      reset  = 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         check_eq("idle after reset", 32'd0, {29'd0, wb_rsp.ack, arvalid, rready});
      end
      wb_read("first miss", line_a + 32'd4, 1, -1);
      check_eq("first miss ar addr", line_a, ar_log[$]);
      wb_read("hit word 0", line_a, 0, 1);
      wb_read("hit word 2", line_a + 32'd8, 0, 1);
      wb_read("hit word 3", line_a + 32'd12, 0, 1);
      wb_read("conflict miss", line_b + 32'd8, 1, -1);
      check_eq("conflict ar addr", line_b, ar_log[$]);
      wb_read("evicted reread", line_a + 32'd12, 1, -1);
      check_eq("evicted ar addr", line_a, ar_log[$]);
      wb_read("error line", err_line + 32'd8, 2, -1);
      check_eq("error first ar addr", err_line, ar_log[$-1]);
      check_eq("error retry ar addr", err_line, ar_log[$]);
      for (int i = 0; i < 6; i++)   // several lines with misses and hits
      begin
         for (int w = 3; w >= 0; w--)
            wb_read("sweep", 32'h0004_0000 + 32'(i * 16 + w * 4), -1, -1);
      end
      if (uut.chk.failed)
      begin
         $display("protocol assertion failed in read_cache_chk");
         $display("Test FAILED");
         $fatal(1, "protocol check");
      end
      else
      begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

// File: build.f
design/cache_pkg.sv
design/line_store.sv
design/cache_lookup.sv
design/line_refill_axi.sv
design/read_cache_top.sv
verification/read_cache_chk.sv
verification/read_cache_tb.sv

// File: Bender.yml
package:
  name: read_cache

sources:
  - files:
      - design/cache_pkg.sv
      - design/line_store.sv
      - design/cache_lookup.sv
      - design/line_refill_axi.sv
      - design/read_cache_top.sv
  - target: test
    files:
      - verification/read_cache_chk.sv
      - verification/read_cache_tb.sv
